/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dns_rx_tb
FILELIST  = dns_rx_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dns_rx_top.f */
verilog/dns_pkg.sv
verilog/eth_ip_rx.sv
verilog/udp_rx.sv
verilog/dns_hdr_parser.sv
verilog/dns_rx_top.sv
sim/dns_rx_asserts.sv
sim/dns_rx_tb.sv

/* sim/dns_rx_asserts.sv */
/*
 * Handshake checks, bound into the DNS receive top level.
 */

`timescale 1ns/1ns

module dns_rx_asserts (
    input logic                 clk,
    input logic                 arst_n_i,
    input dns_pkg::byte_t       s_data_i,
    input logic                 s_valid_i,
    input logic                 s_last_i,
    input logic                 s_ready_o,
    input logic                 rec_valid_o,
    input logic                 rec_ready_i,
    input logic [120:0]         rec_fields
);

    // set once a frame end has entered the pipeline
    logic seen_last_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seen_last_q <= 1'b0;
        end else if (s_valid_i && s_ready_o && s_last_i) begin
            seen_last_q <= 1'b1;
        end
    end

    // stalled input byte held as it is
    a_s_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        s_valid_i && !s_ready_o |=> s_valid_i && $stable(s_data_i) && $stable(s_last_i))
        else $error("input byte changed while stalled");

    // record fields frozen until taken
    a_rec_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        rec_valid_o && !rec_ready_i |=> rec_valid_o && $stable(rec_fields))
        else $error("record changed before rec_ready_i");

    // no record out of reset until some frame has ended
    a_rst: assert property (@(posedge clk) !seen_last_q |-> !rec_valid_o)
        else $error("rec_valid_o high before any frame ended");

endmodule

bind dns_rx_top dns_rx_asserts asserts_inst (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .s_data_i    (s_data_i),
    .s_valid_i   (s_valid_i),
    .s_last_i    (s_last_i),
    .s_ready_o   (s_ready_o),
    .rec_valid_o (rec_valid_o),
    .rec_ready_i (rec_ready_i),
    .rec_fields  ({rec_id_o, rec_qr_o, rec_opcode_o, rec_rcode_o, rec_qdcount_o,
                   rec_ancount_o, rec_src_ip_o, rec_dst_ip_o})
);

/* sim/dns_rx_tb.sv */
/*
 * Testbench for the DNS receive pipeline. Reads frames and expected
 * records from sim/dns_vectors.txt, run from the project root.
 */

`timescale 1ns/1ns

module dns_rx_tb;

    localparam int          CLK_PERIOD   = 4;
    localparam              VEC_FILE     = "sim/dns_vectors.txt";
    localparam int unsigned SEED         = 32'h3ccec6a0;
    localparam int          MEM_WORDS    = 1024;
    localparam int          MAX_VEC      = 32;
    // cycles with rec_ready_i high before the final count
    localparam int          DRAIN_CYCLES = 40;

    logic                 clk;
    logic                 arst_n_i;
    dns_pkg::byte_t       s_data_i;
    logic                 s_valid_i;
    logic                 s_last_i;
    logic                 s_ready_o;
    logic                 rec_valid_o;
    logic                 rec_ready_i;
    logic [15:0]          rec_id_o;
    logic                 rec_qr_o;
    dns_pkg::dns_opcode_e rec_opcode_o;
    logic [3:0]           rec_rcode_o;
    logic [15:0]          rec_qdcount_o;
    logic [15:0]          rec_ancount_o;
    dns_pkg::ip_addr_t    rec_src_ip_o;
    dns_pkg::ip_addr_t    rec_dst_ip_o;

    // raw vector words, then the parsed view of them
    logic [31:0]  vec_mem [MEM_WORDS];
    int           frame_start [MAX_VEC];
    int           frame_len [MAX_VEC];
    logic         has_rec [MAX_VEC];
    logic [31:0]  exp_field [MAX_VEC][8];
    int           nvec = 0;
    int           exp_records = 0;

    // field order matches the vector file
    string field_names [8] = '{"rec_id_o", "rec_qr_o", "rec_opcode_o", "rec_rcode_o",
                               "rec_qdcount_o", "rec_ancount_o", "rec_src_ip_o",
                               "rec_dst_ip_o"};

    logic [120:0] rec_q [$];
    int           pending [$];
    int           rec_count = 0;
    int           errors = 0;
    int           limit_ns = 0;
    logic         draining = 1'b0;

    dns_rx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random record back-pressure, released for the final drain
    initial begin
        rec_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            if (draining) begin
                rec_ready_i = 1'b1;
            end else begin
                rec_ready_i = ($urandom % 3) != 0;
            end
        end
    end

    // every accepted record, in arrival order
    always @(posedge clk) begin
        if (arst_n_i && rec_valid_o && rec_ready_i) begin
            rec_q.push_back({rec_id_o, rec_qr_o, rec_opcode_o, rec_rcode_o,
                             rec_qdcount_o, rec_ancount_o, rec_src_ip_o, rec_dst_ip_o});
            rec_count++;
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: the pipeline stopped before all records came out");
        $display("Errors found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // one byte, held until accepted, then maybe a short idle gap
    task automatic send_byte(input dns_pkg::byte_t b, input logic last);
        s_data_i  = b;
        s_valid_i = 1'b1;
        s_last_i  = last;
        @(posedge clk);
        while (!s_ready_o) @(posedge clk);
        @(negedge clk);
        s_valid_i = 1'b0;
        if ($urandom % 4 == 0) begin
            repeat (1 + $urandom % 3) @(negedge clk);
        end
    endtask

    task automatic drive_frames();
        for (int k = 0; k < nvec; k++) begin
            for (int i = 0; i < frame_len[k]; i++) begin
                send_byte(vec_mem[frame_start[k] + i][7:0], i == frame_len[k] - 1);
            end
        end
    endtask

    // dropped frames are settled by the next clean record or the drain
    task automatic close_pending(input logic clean);
        int idx;
        while (pending.size() > 0) begin
            idx = pending.pop_front();
            if (clean) begin
                $display("test %0d: frame dropped with no record, passed", idx);
            end else begin
                $display("test %0d: a record came out for a frame that should be dropped", idx);
                errors++;
            end
        end
    endtask

    task automatic check_records();
        logic [15:0] id;
        logic        qr;
        logic [3:0]  op;
        logic [3:0]  rc;
        logic [15:0] qd;
        logic [15:0] an;
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] act [8];
        int          errs_before;
        for (int k = 0; k < nvec; k++) begin
            if (!has_rec[k]) begin
                pending.push_back(k);
            end else begin
                while (rec_q.size() == 0) @(posedge clk);
                {id, qr, op, rc, qd, an, src, dst} = rec_q.pop_front();
                close_pending(32'(id) == exp_field[k][0]);
                errs_before = errors;
                act[0] = 32'(id);
                act[1] = 32'(qr);
                act[2] = 32'(op);
                act[3] = 32'(rc);
                act[4] = 32'(qd);
                act[5] = 32'(an);
                act[6] = src;
                act[7] = dst;
                for (int f = 0; f < 8; f++) begin
                    check_value(field_names[f], exp_field[k][f], act[f]);
                end
                if (errors == errs_before) begin
                    $display("test %0d: record %h passed", k, id);
                end else begin
                    $display("test %0d: record %h failed", k, id);
                end
            end
        end
    endtask

    initial begin
        int p;
        int total_bytes;
        s_data_i  = '0;
        s_valid_i = 1'b0;
        s_last_i  = 1'b0;
        arst_n_i  = 1'b1;
        void'($urandom(SEED));

        // length, bytes, record flag, then eight fields if flagged
        $readmemh(VEC_FILE, vec_mem);
        p = 0;
        total_bytes = 0;
        while (vec_mem[p] != 32'd0 && nvec < MAX_VEC) begin
            frame_len[nvec]   = int'(vec_mem[p]);
            frame_start[nvec] = p + 1;
            p = p + 1 + frame_len[nvec];
            has_rec[nvec] = vec_mem[p][0];
            p++;
            if (has_rec[nvec]) begin
                for (int f = 0; f < 8; f++) begin
                    exp_field[nvec][f] = vec_mem[p + f];
                end
                p += 8;
                exp_records++;
            end
            total_bytes += frame_len[nvec];
            nvec++;
        end
        limit_ns = total_bytes * CLK_PERIOD * 8 + 2000;

        // two clock reset, released on a falling edge
        #1;
        arst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        fork
            drive_frames();
            check_records();
        join

        draining = 1'b1;
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (rec_q.size() != 0) begin
            $display("%0d record(s) came out beyond the expected ones", rec_q.size());
            errors++;
        end
        close_pending(rec_q.size() == 0);
        $display("tests %0d, records %0d of %0d, errors %0d",
                 nvec, rec_count, exp_records, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sim/dns_vectors.txt */
// frame: byte count, then the bytes; then 1 and id qr opcode rcode qdcount ancount src dst,
// or 0 for no record; a count of 0 ends the list
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 28 00 01 00 00 40 11 00 00
c0 a8 01 0a 08 08 08 08  13 88 00 35 00 14 00 00  12 34 01 00 00 01 00 00 00 00 00 00
1  1234 0 0 0 0001 0000 c0a8010a 08080808  // query to port 53
3e  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 30 00 02 00 00 40 11 00 00
08 08 08 08 c0 a8 01 0a  00 35 13 88 00 1c 00 00  ab cd 81 83 00 01 00 02 00 00 00 00
c0 0c 00 01 00 01 00 00
1  abcd 1 0 3 0001 0002 08080808 c0a8010a  // response with answer bytes
36  00 11 22 33 44 55 66 77 88 99 aa bb 86 dd  45 00 00 28 00 03 00 00 40 11 00 00
c0 a8 01 0a 08 08 08 08  13 88 00 35 00 14 00 00  00 03 01 00 00 01 00 00 00 00 00 00
0  // ipv6 ethertype
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 28 00 04 00 00 40 06 00 00
c0 a8 01 0a 08 08 08 08  13 88 00 35 00 14 00 00  00 04 01 00 00 01 00 00 00 00 00 00
0  // tcp protocol
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  46 00 00 28 00 05 00 00 40 11 00 00
c0 a8 01 0a 08 08 08 08  13 88 00 35 00 14 00 00  00 05 01 00 00 01 00 00 00 00 00 00
0  // ihl 6
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 28 00 06 00 00 40 11 00 00
c0 a8 01 0a 08 08 08 08  00 50 01 bb 00 14 00 00  00 06 01 00 00 01 00 00 00 00 00 00
0  // ports 80 and 443
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 28 00 07 00 00 40 11 00 00
0a 00 00 01 0a 00 00 35  c3 50 00 35 00 14 00 00  5a 5a 10 00 00 01 00 00 00 00 00 00
1  5a5a 0 2 0 0001 0000 0a000001 0a000035  // status query after the drops
32  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 24 00 08 00 00 40 11 00 00
c0 a8 01 0a 08 08 08 08  13 88 00 35 00 10 00 00  00 08 01 00 00 01 00 00
0  // 8 dns bytes only
36  00 11 22 33 44 55 66 77 88 99 aa bb 08 00  45 00 00 28 00 09 00 00 40 11 00 00
c0 a8 01 35 c0 a8 01 0a  00 35 00 35 00 14 00 00  0f 0f a0 05 00 01 00 01 00 00 00 00
1  0f0f 1 4 5 0001 0001 c0a80135 c0a8010a  // notify response
0

/* verilog/dns_hdr_parser.sv */
/*
 * Final stage. Picks the fixed 12-byte DNS header out of the payload
 * and presents one record per frame on a valid/ready handshake.
 */

`timescale 1ns/1ns

module dns_hdr_parser (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // dns payload in
    input  dns_pkg::byte_t       s_data_i,
    input  logic                 s_valid_i,
    input  logic                 s_last_i,
    output logic                 s_ready_o,
    input  dns_pkg::ip_addr_t    s_src_ip_i,
    input  dns_pkg::ip_addr_t    s_dst_ip_i,
    // record out
    output logic                 rec_valid_o,
    input  logic                 rec_ready_i,
    output logic [15:0]          rec_id_o,
    output logic                 rec_qr_o,
    output dns_pkg::dns_opcode_e rec_opcode_o,
    output logic [3:0]           rec_rcode_o,
    output logic [15:0]          rec_qdcount_o,
    output logic [15:0]          rec_ancount_o,
    output dns_pkg::ip_addr_t    rec_src_ip_o,
    output dns_pkg::ip_addr_t    rec_dst_ip_o
);

    // RX_HDR collects, RX_DROP skips the rest of the message
    dns_pkg::rx_state_e   state_q;
    logic [3:0]           cnt_q;
    logic                 s_fire;
    logic                 hdr_full;
    logic                 rec_valid_q;

    // record fields
    logic [15:0]          id_q;
    logic                 qr_q;
    dns_pkg::dns_opcode_e opcode_q;
    logic [3:0]           rcode_q;
    logic [15:0]          qdcount_q;
    logic [15:0]          ancount_q;
    dns_pkg::ip_addr_t    src_ip_q;
    dns_pkg::ip_addr_t    dst_ip_q;

    // stall while a record waits, fields are shared with the next frame
    assign s_ready_o = !rec_valid_q || rec_ready_i;
    assign s_fire    = s_valid_i && s_ready_o;
    // true on the 12th header byte and after it
    assign hdr_full  = (state_q == dns_pkg::RX_DROP) ||
                       (cnt_q == 4'(dns_pkg::DNS_HDR_BYTES - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dns_pkg::RX_HDR;
            cnt_q   <= '0;
        end else if (s_fire) begin
            if (s_last_i) begin
                state_q <= dns_pkg::RX_HDR;
                cnt_q   <= '0;
            end else if (state_q == dns_pkg::RX_HDR) begin
                if (hdr_full) begin
                    state_q <= dns_pkg::RX_DROP;
                end else begin
                    cnt_q <= cnt_q + 4'd1;
                end
            end
        end
    end

    // header bytes land in their fields by position
    always_ff @(posedge clk) begin
        if (s_fire && (state_q == dns_pkg::RX_HDR)) begin
            case (cnt_q)
                4'd0: begin
                    id_q[15:8] <= s_data_i;
                    // addresses are constant through the frame
                    src_ip_q   <= s_src_ip_i;
                    dst_ip_q   <= s_dst_ip_i;
                end
                4'd1: id_q[7:0] <= s_data_i;
                // flags high byte
                4'd2: begin
                    qr_q     <= s_data_i[7];
                    opcode_q <= dns_pkg::dns_opcode_e'(s_data_i[6:3]);
                end
                // flags low byte
                4'd3: rcode_q <= s_data_i[3:0];
                4'd4: qdcount_q[15:8] <= s_data_i;
                4'd5: qdcount_q[7:0]  <= s_data_i;
                4'd6: ancount_q[15:8] <= s_data_i;
                4'd7: ancount_q[7:0]  <= s_data_i;
                // nscount and arcount not reported
                default: ;
            endcase
        end
    end

    // record only when the full header arrived
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rec_valid_q <= 1'b0;
        end else if (s_fire && s_last_i && hdr_full) begin
            rec_valid_q <= 1'b1;
        end else if (rec_ready_i) begin
            rec_valid_q <= 1'b0;
        end
    end

    assign rec_valid_o   = rec_valid_q;
    assign rec_id_o      = id_q;
    assign rec_qr_o      = qr_q;
    assign rec_opcode_o  = opcode_q;
    assign rec_rcode_o   = rcode_q;
    assign rec_qdcount_o = qdcount_q;
    assign rec_ancount_o = ancount_q;
    assign rec_src_ip_o  = src_ip_q;
    assign rec_dst_ip_o  = dst_ip_q;

endmodule

/* verilog/dns_pkg.sv */
/*
 * Shared types and protocol constants for the DNS receive pipeline.
 * Every RTL stage refers to these through dns_pkg:: scoped names.
 */

package dns_pkg;

    // stream and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // header lengths in bytes
    localparam int ETH_HDR_BYTES = 14;
    // no options supported
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int DNS_HDR_BYTES = 12;

    // field offsets inside the ipv4 header
    localparam int IP_PROTO_OFF = 9;
    localparam int IP_SRC_OFF   = 12;
    localparam int IP_DST_OFF   = 16;

    // values the filters look for
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [3:0]  IP_VERSION     = 4'd4;
    localparam byte_t       IP_PROTO_UDP   = 8'd17;
    localparam port_t       DNS_PORT       = 16'd53;

    // header stripping state, shared by all three stages
    typedef enum logic [1:0] {
        // counting header bytes
        RX_HDR     = 2'd0,
        // forwarding payload
        RX_PAYLOAD = 2'd1,
        // discarding until last
        RX_DROP    = 2'd2
    } rx_state_e;

    // dns opcode field
    // values outside the list are carried through as they are
    typedef enum logic [3:0] {
        OP_QUERY  = 4'd0,
        OP_IQUERY = 4'd1,
        OP_STATUS = 4'd2,
        OP_NOTIFY = 4'd4
    } dns_opcode_e;

endpackage

/* verilog/dns_rx_top.sv */
/*
 * DNS receive pipeline top level. Ethernet frames in, one DNS header
 * record per accepted frame out.
 */

`timescale 1ns/1ns

module dns_rx_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // frame stream from the mac
    input  dns_pkg::byte_t       s_data_i,
    input  logic                 s_valid_i,
    input  logic                 s_last_i,
    output logic                 s_ready_o,
    // dns header records
    output logic                 rec_valid_o,
    input  logic                 rec_ready_i,
    output logic [15:0]          rec_id_o,
    output logic                 rec_qr_o,
    output dns_pkg::dns_opcode_e rec_opcode_o,
    output logic [3:0]           rec_rcode_o,
    output logic [15:0]          rec_qdcount_o,
    output logic [15:0]          rec_ancount_o,
    output dns_pkg::ip_addr_t    rec_src_ip_o,
    output dns_pkg::ip_addr_t    rec_dst_ip_o
);

    // ip to udp
    dns_pkg::byte_t    seg_data;
    logic              seg_valid;
    logic              seg_last;
    logic              seg_ready;
    dns_pkg::ip_addr_t seg_src_ip;
    dns_pkg::ip_addr_t seg_dst_ip;

    // udp to dns
    dns_pkg::byte_t    dns_data;
    logic              dns_valid;
    logic              dns_last;
    logic              dns_ready;
    dns_pkg::ip_addr_t dns_src_ip;
    dns_pkg::ip_addr_t dns_dst_ip;

    eth_ip_rx eth_ip_rx_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .s_data_i   (s_data_i),
        .s_valid_i  (s_valid_i),
        .s_last_i   (s_last_i),
        .s_ready_o  (s_ready_o),
        .m_data_o   (seg_data),
        .m_valid_o  (seg_valid),
        .m_last_o   (seg_last),
        .m_ready_i  (seg_ready),
        .m_src_ip_o (seg_src_ip),
        .m_dst_ip_o (seg_dst_ip)
    );

    udp_rx udp_rx_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .s_data_i   (seg_data),
        .s_valid_i  (seg_valid),
        .s_last_i   (seg_last),
        .s_ready_o  (seg_ready),
        .s_src_ip_i (seg_src_ip),
        .s_dst_ip_i (seg_dst_ip),
        .m_data_o   (dns_data),
        .m_valid_o  (dns_valid),
        .m_last_o   (dns_last),
        .m_ready_i  (dns_ready),
        .m_src_ip_o (dns_src_ip),
        .m_dst_ip_o (dns_dst_ip)
    );

    dns_hdr_parser dns_hdr_parser_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .s_data_i      (dns_data),
        .s_valid_i     (dns_valid),
        .s_last_i      (dns_last),
        .s_ready_o     (dns_ready),
        .s_src_ip_i    (dns_src_ip),
        .s_dst_ip_i    (dns_dst_ip),
        .rec_valid_o   (rec_valid_o),
        .rec_ready_i   (rec_ready_i),
        .rec_id_o      (rec_id_o),
        .rec_qr_o      (rec_qr_o),
        .rec_opcode_o  (rec_opcode_o),
        .rec_rcode_o   (rec_rcode_o),
        .rec_qdcount_o (rec_qdcount_o),
        .rec_ancount_o (rec_ancount_o),
        .rec_src_ip_o  (rec_src_ip_o),
        .rec_dst_ip_o  (rec_dst_ip_o)
    );

endmodule

/* verilog/eth_ip_rx.sv */
/*
 * First receive stage. Walks the Ethernet and IPv4 headers, drops
 * anything that is not IPv4/UDP with a plain 20-byte header, and
 * forwards the UDP segment with both IP addresses as sideband.
 */

`timescale 1ns/1ns

module eth_ip_rx (
    input  logic              clk,
    input  logic              arst_n_i,
    // ethernet frame in, fcs already removed
    input  dns_pkg::byte_t    s_data_i,
    input  logic              s_valid_i,
    input  logic              s_last_i,
    output logic              s_ready_o,
    // udp segment out
    output dns_pkg::byte_t    m_data_o,
    output logic              m_valid_o,
    output logic              m_last_o,
    input  logic              m_ready_i,
    output dns_pkg::ip_addr_t m_src_ip_o,
    output dns_pkg::ip_addr_t m_dst_ip_o
);

    // header walk
    dns_pkg::rx_state_e state_q;
    logic [5:0]         cnt_q;
    logic               hdr_bad;
    logic               hdr_end;
    logic               s_fire;
    logic               load;

    // addresses as they go by
    dns_pkg::ip_addr_t  src_ip_q;
    dns_pkg::ip_addr_t  dst_ip_q;

    // one-entry output register
    dns_pkg::byte_t     m_data_q;
    logic               m_valid_q;
    logic               m_last_q;
    dns_pkg::ip_addr_t  m_src_ip_q;
    dns_pkg::ip_addr_t  m_dst_ip_q;

    // header and drop bytes never touch the output register
    assign s_ready_o = (state_q != dns_pkg::RX_PAYLOAD) || !m_valid_q || m_ready_i;
    assign s_fire    = s_valid_i && s_ready_o;
    assign load      = s_fire && (state_q == dns_pkg::RX_PAYLOAD);
    // 34th byte closes the ipv4 header
    assign hdr_end   = cnt_q == 6'(dns_pkg::ETH_HDR_BYTES + dns_pkg::IP_HDR_BYTES - 1);

    // per-byte header checks
    always_comb begin
        hdr_bad = 1'b0;
        case (cnt_q)
            // ethertype high then low byte
            6'(dns_pkg::ETH_HDR_BYTES - 2):
                hdr_bad = s_data_i != dns_pkg::ETHERTYPE_IPV4[15:8];
            6'(dns_pkg::ETH_HDR_BYTES - 1):
                hdr_bad = s_data_i != dns_pkg::ETHERTYPE_IPV4[7:0];
            // version and ihl share the first ip byte
            6'(dns_pkg::ETH_HDR_BYTES):
                hdr_bad = (s_data_i[7:4] != dns_pkg::IP_VERSION) ||
                          (s_data_i[3:0] != 4'(dns_pkg::IP_HDR_BYTES / 4));
            6'(dns_pkg::ETH_HDR_BYTES + dns_pkg::IP_PROTO_OFF):
                hdr_bad = s_data_i != dns_pkg::IP_PROTO_UDP;
            default:
                hdr_bad = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dns_pkg::RX_HDR;
            cnt_q   <= '0;
        end else if (s_fire) begin
            case (state_q)
                dns_pkg::RX_HDR: begin
                    if (s_last_i) begin
                        // frame ended inside the header
                        cnt_q <= '0;
                    end else if (hdr_bad) begin
                        state_q <= dns_pkg::RX_DROP;
                    end else if (hdr_end) begin
                        state_q <= dns_pkg::RX_PAYLOAD;
                    end else begin
                        cnt_q <= cnt_q + 6'd1;
                    end
                end
                dns_pkg::RX_PAYLOAD, dns_pkg::RX_DROP: begin
                    if (s_last_i) begin
                        state_q <= dns_pkg::RX_HDR;
                        cnt_q   <= '0;
                    end
                end
                default: begin
                    state_q <= dns_pkg::RX_HDR;
                end
            endcase
        end
    end

    // shift in source then destination address
    always_ff @(posedge clk) begin
        if (s_fire && (state_q == dns_pkg::RX_HDR)) begin
            if ((cnt_q >= 6'(dns_pkg::ETH_HDR_BYTES + dns_pkg::IP_SRC_OFF)) &&
                (cnt_q <  6'(dns_pkg::ETH_HDR_BYTES + dns_pkg::IP_DST_OFF))) begin
                src_ip_q <= {src_ip_q[23:0], s_data_i};
            end
            if (cnt_q >= 6'(dns_pkg::ETH_HDR_BYTES + dns_pkg::IP_DST_OFF)) begin
                dst_ip_q <= {dst_ip_q[23:0], s_data_i};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_valid_q <= 1'b0;
        end else if (load) begin
            m_valid_q <= 1'b1;
        end else if (m_ready_i) begin
            m_valid_q <= 1'b0;
        end
    end

    // addresses ride along with every payload byte
    always_ff @(posedge clk) begin
        if (load) begin
            m_data_q   <= s_data_i;
            m_last_q   <= s_last_i;
            m_src_ip_q <= src_ip_q;
            m_dst_ip_q <= dst_ip_q;
        end
    end

    assign m_data_o   = m_data_q;
    assign m_valid_o  = m_valid_q;
    assign m_last_o   = m_last_q;
    assign m_src_ip_o = m_src_ip_q;
    assign m_dst_ip_o = m_dst_ip_q;

endmodule

/* verilog/udp_rx.sv */
/*
 * Second receive stage. Strips the UDP header and passes on only
 * datagrams to or from port 53, with the IP addresses kept alongside.
 */

`timescale 1ns/1ns

module udp_rx (
    input  logic              clk,
    input  logic              arst_n_i,
    // udp segment in
    input  dns_pkg::byte_t    s_data_i,
    input  logic              s_valid_i,
    input  logic              s_last_i,
    output logic              s_ready_o,
    input  dns_pkg::ip_addr_t s_src_ip_i,
    input  dns_pkg::ip_addr_t s_dst_ip_i,
    // dns payload out
    output dns_pkg::byte_t    m_data_o,
    output logic              m_valid_o,
    output logic              m_last_o,
    input  logic              m_ready_i,
    output dns_pkg::ip_addr_t m_src_ip_o,
    output dns_pkg::ip_addr_t m_dst_ip_o
);

    dns_pkg::rx_state_e state_q;
    logic [2:0]         cnt_q;
    dns_pkg::port_t     src_port_q;
    dns_pkg::port_t     dst_port_q;
    logic               hdr_end;
    logic               is_dns;
    logic               s_fire;
    logic               load;

    // output register
    dns_pkg::byte_t     m_data_q;
    logic               m_valid_q;
    logic               m_last_q;
    dns_pkg::ip_addr_t  m_src_ip_q;
    dns_pkg::ip_addr_t  m_dst_ip_q;

    assign s_ready_o = (state_q != dns_pkg::RX_PAYLOAD) || !m_valid_q || m_ready_i;
    assign s_fire    = s_valid_i && s_ready_o;
    assign load      = s_fire && (state_q == dns_pkg::RX_PAYLOAD);
    assign hdr_end   = cnt_q == 3'(dns_pkg::UDP_HDR_BYTES - 1);
    // either direction counts
    assign is_dns    = (src_port_q == dns_pkg::DNS_PORT) || (dst_port_q == dns_pkg::DNS_PORT);

    // ports sit in the first four bytes
    always_ff @(posedge clk) begin
        if (s_fire && (state_q == dns_pkg::RX_HDR) && !cnt_q[2]) begin
            if (!cnt_q[1]) begin
                src_port_q <= {src_port_q[7:0], s_data_i};
            end else begin
                dst_port_q <= {dst_port_q[7:0], s_data_i};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dns_pkg::RX_HDR;
            cnt_q   <= '0;
        end else if (s_fire) begin
            case (state_q)
                dns_pkg::RX_HDR: begin
                    cnt_q <= cnt_q + 3'd1;
                    if (s_last_i) begin
                        // short datagram, nothing to forward
                        cnt_q <= '0;
                    end else if (hdr_end) begin
                        state_q <= is_dns ? dns_pkg::RX_PAYLOAD : dns_pkg::RX_DROP;
                    end
                end
                dns_pkg::RX_PAYLOAD, dns_pkg::RX_DROP: begin
                    if (s_last_i) begin
                        state_q <= dns_pkg::RX_HDR;
                    end
                end
                default: begin
                    state_q <= dns_pkg::RX_HDR;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_valid_q <= 1'b0;
        end else if (load) begin
            m_valid_q <= 1'b1;
        end else if (m_ready_i) begin
            m_valid_q <= 1'b0;
        end
    end

    // sideband re-registered with each byte
    always_ff @(posedge clk) begin
        if (load) begin
            m_data_q   <= s_data_i;
            m_last_q   <= s_last_i;
            m_src_ip_q <= s_src_ip_i;
            m_dst_ip_q <= s_dst_ip_i;
        end
    end

    assign m_data_o   = m_data_q;
    assign m_valid_o  = m_valid_q;
    assign m_last_o   = m_last_q;
    assign m_src_ip_o = m_src_ip_q;
    assign m_dst_ip_o = m_dst_ip_q;

endmodule
